//--- verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int img_size = 8;
    localparam int pix_w = 20;
    localparam int frac_w = 16;
    localparam int taps = 9;
    localparam int addr_w = $clog2(img_size * img_size);
    localparam int acc_w = 44;   // 40-bit product plus guard bits

    typedef logic signed [pix_w-1:0] pixel_t;
    typedef logic [addr_w-1:0] img_addr_t;
    typedef logic [3:0] tap_t;

    // s3.16 weights in row-major window order
    localparam pixel_t kernel_w [taps] = '{
        20'h08000, 20'h04000, 20'hFC000,
        20'h02000, 20'h10000, 20'hF8000,
        20'hFE000, 20'h06000, 20'hF4000
    };

    localparam pixel_t kernel_bias = 20'hFF000;   // -1/16

    typedef struct packed {
        img_addr_t addr;
        pixel_t value;
    } conv_result_t;

endpackage

`default_nettype wire

//--- verilog/window_counter.sv
`default_nettype none

module window_counter import conv_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      step,
    input  wire logic      clear,
    output img_addr_t      row,
    output img_addr_t      col,
    output tap_t           tap,
    output logic           last_tap,
    output logic           last_pixel
);

    localparam tap_t tap_max = tap_t'(taps - 1);
    localparam img_addr_t edge_max = img_addr_t'(img_size - 1);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            row <= '0;
            col <= '0;
            tap <= '0;
        end else if (step) begin
            if (tap == tap_max) begin
                tap <= '0;
                // window done so on to the next output pixel
                if (col == edge_max) begin
                    col <= '0;
                    row <= (row == edge_max) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                tap <= tap + 1'b1;
            end
        end
    end

    assign last_tap = (tap == tap_max);
    assign last_pixel = (row == edge_max) && (col == edge_max);

endmodule

`default_nettype wire

//--- verilog/pad_fetch.sv
`default_nettype none

module pad_fetch import conv_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      step,
    input  wire img_addr_t row,
    input  wire img_addr_t col,
    input  wire tap_t      tap,
    output img_addr_t      iaddr,
    input  wire pixel_t    idata,
    output logic           tap_valid,
    output tap_t           tap_out,
    output pixel_t         pixel
);

    logic signed [1:0] dr, dc;
    logic signed [addr_w+1:0] r_pos, c_pos;
    logic in_range;
    logic pad_q;

    // tap -> window offset
    always_comb begin
        case (tap)
            4'd0, 4'd1, 4'd2: dr = -2'sd1;
            4'd3, 4'd4, 4'd5: dr = 2'sd0;
            default:          dr = 2'sd1;
        endcase
        case (tap)
            4'd0, 4'd3, 4'd6: dc = -2'sd1;
            4'd1, 4'd4, 4'd7: dc = 2'sd0;
            default:          dc = 2'sd1;
        endcase
    end

    assign r_pos = $signed({2'b00, row}) + dr;
    assign c_pos = $signed({2'b00, col}) + dc;
    assign in_range = (r_pos >= 0) && (r_pos < img_size) && (c_pos >= 0) && (c_pos < img_size);
    assign iaddr = in_range ? img_addr_t'(r_pos * img_size + c_pos) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            tap_valid <= 1'b0;
        end else begin
            tap_valid <= step;
        end
    end

    // travels alongside the memory read
    always_ff @(posedge clk) begin
        pad_q <= !in_range;
        tap_out <= tap;
    end

    assign pixel = pad_q ? '0 : idata;   // zero padding

endmodule

`default_nettype wire

//--- verilog/conv_mac.sv
`default_nettype none

module conv_mac import conv_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      clear,
    input  wire logic      tap_valid,
    input  wire tap_t      tap_in,
    input  wire pixel_t    pixel,
    input  wire logic      finish,
    input  wire logic      res_ready,
    input  wire img_addr_t pix_addr,
    output logic           res_valid,
    output conv_result_t   res
);

    logic signed [2*pix_w-1:0] product;
    logic signed [acc_w-1:0] addend;
    logic signed [acc_w-1:0] acc;
    img_addr_t pos;
    pixel_t rounded;
    pixel_t biased;
    pixel_t relu;

    assign product = pixel * kernel_w[tap_in];
    assign addend = product;   // sign extension

    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (tap_valid) begin
            acc <= ((tap_in == '0) ? '0 : acc) + addend;
        end
    end

    // counter has moved on by finish, so grab position at tap 0
    always_ff @(posedge clk) begin
        if (tap_valid && tap_in == '0) begin
            pos <= pix_addr;
        end
    end

    // round half up, then bias and relu
    assign rounded = acc[frac_w +: pix_w] + {{(pix_w-1){1'b0}}, acc[frac_w-1]};
    assign biased = rounded + kernel_bias;
    assign relu = biased[pix_w-1] ? '0 : biased;

    always_ff @(posedge clk) begin
        if (finish) begin
            res.addr <= pos;
            res.value <= relu;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (finish) begin
            res_valid <= 1'b1;
        end else if (res_valid && res_ready) begin
            res_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/conv_ctrl.sv
`default_nettype none

module conv_ctrl import conv_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  wire logic last_tap,
    input  wire logic last_pixel,
    input  wire logic res_valid,
    input  wire logic res_ready,
    output logic      busy,
    output logic      step,
    output logic      clear,
    output logic      finish
);

    typedef enum logic [2:0] {
        s_idle,
        s_fetch,
        s_drain,
        s_finish,
        s_output
    } state_t;

    state_t state;
    logic final_pix;   // current window is the image's last
    logic xfer;

    assign xfer = res_valid && res_ready;

    assign step = (state == s_fetch);
    assign clear = (state == s_idle) && start;
    assign finish = (state == s_finish);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            busy <= 1'b0;
            final_pix <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        busy <= 1'b1;
                        final_pix <= 1'b0;
                        state <= s_fetch;
                    end
                end
                s_fetch: begin
                    // last_pixel still reflects this window on its last tap
                    if (last_tap) begin
                        final_pix <= last_pixel;
                        state <= s_drain;
                    end
                end
                s_drain: begin
                    state <= s_finish;   // last pixel in flight
                end
                s_finish: begin
                    state <= s_output;
                end
                s_output: begin
                    if (xfer) begin
                        if (final_pix) begin
                            busy <= 1'b0;
                            state <= s_idle;
                        end else begin
                            state <= s_fetch;
                        end
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/conv_top.sv
`default_nettype none

module conv_top import conv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   start,
    output logic        busy,
    output img_addr_t   iaddr,
    input  wire pixel_t idata,
    output logic        res_valid,
    input  wire logic   res_ready,
    output conv_result_t res
);

    logic step, clear, finish;
    logic last_tap, last_pixel;
    img_addr_t row, col;
    tap_t tap;
    logic tap_valid;
    tap_t tap_q;
    pixel_t pixel;
    img_addr_t pix_addr;

    assign pix_addr = img_addr_t'(row * img_size + col);   // raster address

    conv_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .last_tap   (last_tap),
        .last_pixel (last_pixel),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .busy       (busy),
        .step       (step),
        .clear      (clear),
        .finish     (finish)
    );

    window_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .clear      (clear),
        .row        (row),
        .col        (col),
        .tap        (tap),
        .last_tap   (last_tap),
        .last_pixel (last_pixel)
    );

    pad_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .row       (row),
        .col       (col),
        .tap       (tap),
        .iaddr     (iaddr),
        .idata     (idata),
        .tap_valid (tap_valid),
        .tap_out   (tap_q),
        .pixel     (pixel)
    );

    conv_mac u_mac (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .tap_valid (tap_valid),
        .tap_in    (tap_q),
        .pixel     (pixel),
        .finish    (finish),
        .res_ready (res_ready),
        .pix_addr  (pix_addr),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int half_period = 2;   // period of 4

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tests/conv_props.sv
`default_nettype none

module conv_props import conv_pkg::*; (
    input wire logic         clk,
    input wire logic         reset,
    input wire logic         busy,
    input wire logic         res_valid,
    input wire logic         res_ready,
    input wire conv_result_t res
);

    // stalled result holds until taken
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("result changed or dropped while stalled");

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !busy && !res_valid)
        else $error("busy or res_valid high right after reset");

    valid_needs_busy: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> busy)
        else $error("res_valid high while not busy");

endmodule

`default_nettype wire

//--- tests/conv_tb.sv
`default_nettype none

module conv_tb import conv_pkg::*; ();

    localparam int npix = img_size * img_size;
    localparam int runs = 2;
    localparam int clk_period = 4;
    localparam int timeout = npix * 20 * runs * clk_period + 400;   // 20 cycles per result
    localparam int drive_delay = 1;

    logic clk;
    logic reset;
    logic start;
    logic res_ready;
    logic busy;
    logic res_valid;
    img_addr_t iaddr;
    pixel_t idata = '0;
    conv_result_t res;

    pixel_t testdata [2*npix];   // pixels, then expected values
    pixel_t img_mem [npix];
    pixel_t expected [npix];
    logic [31:0] rng;
    int errors;

    tb_clock u_clock (
        .clk (clk)
    );

    conv_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .busy      (busy),
        .iaddr     (iaddr),
        .idata     (idata),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    bind conv_top conv_props u_props (
        .clk       (clk),
        .reset     (reset),
        .busy      (busy),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    // image memory returning data one cycle after the address
    always @(posedge clk) begin : mem_model
        img_addr_t rd_addr;
        rd_addr = iaddr;
        #drive_delay;
        idata = img_mem[rd_addr];
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input string name, input conv_result_t exp_res,
                                input conv_result_t act_res);
        if (act_res !== exp_res) begin
            errors++;
            $display("FAILED %s: expected addr %0d value 0x%05h, actual addr %0d value 0x%05h",
                     name, exp_res.addr, exp_res.value, act_res.addr, act_res.value);
            report_failure();
        end
    endtask

    task automatic check_busy(input string name, input logic exp_busy, input logic act_busy);
        if (act_busy !== exp_busy) begin
            errors++;
            $display("FAILED %s: expected busy %b, actual busy %b", name, exp_busy, act_busy);
            report_failure();
        end
    endtask

    task automatic load_testdata();
        int i;
        testdata[2*npix-1] = pixel_t'(20'h80000);   // negative marker a full file overwrites
        $readmemh("tests/conv_testdata.hex", testdata);
        for (i = 0; i < npix; i++) begin
            img_mem[i] = testdata[i];
            expected[i] = testdata[npix + i];
        end
        if ($isunknown(testdata[2*npix-1]) || testdata[2*npix-1] < 0) begin
            $display("test data file is missing or too short");
            report_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic idle_cycles(input int n);
        int i;
        res_ready = 1'b1;
        for (i = 0; i < n; i++) begin
            next_cycle();
            if (res_valid) begin
                errors++;
                $display("result stream became valid while the engine was idle");
                report_failure();
            end
        end
    endtask

    // one full image under random back-pressure
    task automatic run_image(input int run);
        int count;
        conv_result_t exp_res;
        count = 0;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_busy($sformatf("run %0d busy after start", run), 1'b1, busy);
        while (count < npix) begin
            rng = xorshift(rng);
            res_ready = rng[0];
            if (res_valid && res_ready) begin   // transfer on the coming edge
                exp_res.addr = img_addr_t'(count);
                exp_res.value = expected[count];
                check_result($sformatf("run %0d pixel %0d", run, count), exp_res, res);
                count++;
            end
            next_cycle();
        end
        check_busy($sformatf("run %0d busy after last result", run), 1'b0, busy);
    endtask

    initial begin : stimulus
        int run;
        errors = 0;
        rng = 32'd21;
        reset = 1'b1;
        start = 1'b0;
        res_ready = 1'b0;
        load_testdata();
        repeat (4) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        check_busy("busy after reset", 1'b0, busy);
        for (run = 0; run < runs; run++) begin
            idle_cycles(3);
            run_image(run);
        end
        idle_cycles(3);
        if (errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure();
        end
    end

    initial begin : watchdog
        #(timeout);
        $display("timeout: the design hung before all results were transferred");
        report_failure();
    end

endmodule

`default_nettype wire

//--- tests/conv_testdata.hex
// lines 1-8: image pixels, s3.16 hex, raster order, one image row per line
// lines 9-16: expected result values, same order, address equals position
02D51 019C9 019C9 019C9 019C9 019C9 019C9 019C9
019C9 019C9 019C9 019C9 019C9 019C9 019C9 019C9
019C9 019C9 019C9 019C9 019C9 019C9 019C9 FFE71
019C9 019C9 019C9 00641 019C9 019C9 019C9 019C9
019C9 019C9 019C9 019C9 019C9 019C9 019C9 019C9
019C9 019C9 019C9 019C9 019C9 029CD 019C9 019C9
019C9 019C9 019C9 019C9 019C9 019C9 019C9 019C9
019C9 019C9 019C9 019C9 019C9 019C9 019C9 02277
006C1 00000 00000 00000 00000 00000 00000 01374
00000 009E2 0001E 0001E 0001E 0001E 014A0 01C8A
00000 0001E 00EC4 00000 0028F 0001E 00DCA 00B73
00000 0001E 009E2 00000 00000 0001E 006F4 01FF5
00000 0001E 00500 00000 00000 0061F 00000 026CB
00000 0001E 0001E 0001E 00000 01022 0021E 026CB
00000 0001E 0001E 0001E 00000 0041F 0019D 02A0C
00000 00D02 00D02 00D02 00D02 00D02 008AB 02907

//--- list.f
verilog/conv_pkg.sv
verilog/window_counter.sv
verilog/pad_fetch.sv
verilog/conv_mac.sv
verilog/conv_ctrl.sv
verilog/conv_top.sv
tests/tb_clock.sv
tests/conv_props.sv
tests/conv_tb.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module conv_tb -o conv_sim &&
./obj_dir/conv_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
